// File: design/alu.sv
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  alu_op_t op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {31'b0, lt_signed};
            alu_sltu: result = {31'b0, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = word_t'($signed(src1) >>> shamt);
            alu_lui:  result = src2;       // immediate already sits in the upper 20 bits.
            default:  result = src1 + src2;
        endcase
    end
endmodule

// File: design/branch_unit.sv
`timescale 1ns/10ps

module branch_unit import cpu_pkg::*; (
    input  br_kind_t kind,
    input  word_t    pc,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    input  word_t    offs,
    output logic     taken,
    output word_t    target
);
    logic equal;

    assign equal = (rj_value == rkd_value);

    always_comb begin
        case (kind)
            br_beq:                taken = equal;
            br_bne:                taken = !equal;
            br_b, br_bl, br_jirl:  taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // jirl is register relative, every other kind is pc relative.
    assign target = (kind == br_jirl) ? rj_value + offs : pc + offs;
endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------------------
    // widths and constants
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int    reg_count = 32;
    localparam word_t reset_pc  = 32'h1c00_0000; // first fetch address.

    // 3R and shift-immediate forms, matched on inst[31:15].
    localparam logic [16:0] op17_add_w  = 17'h00020;
    localparam logic [16:0] op17_sub_w  = 17'h00022;
    localparam logic [16:0] op17_slt    = 17'h00024;
    localparam logic [16:0] op17_sltu   = 17'h00025;
    localparam logic [16:0] op17_nor    = 17'h00028;
    localparam logic [16:0] op17_and    = 17'h00029;
    localparam logic [16:0] op17_or     = 17'h0002a;
    localparam logic [16:0] op17_xor    = 17'h0002b;
    localparam logic [16:0] op17_slli_w = 17'h00081;
    localparam logic [16:0] op17_srli_w = 17'h00089;
    localparam logic [16:0] op17_srai_w = 17'h00091;

    // 2RI12 forms, matched on inst[31:22].
    localparam logic [9:0] op10_addi_w = 10'h00a;
    localparam logic [9:0] op10_ld_w   = 10'h0a2;
    localparam logic [9:0] op10_st_w   = 10'h0a6;

    localparam logic [6:0] op7_lu12i_w = 7'h0a;  // matched on inst[31:25].

    // branch forms, matched on inst[31:26].
    localparam logic [5:0] op6_jirl = 6'h13;
    localparam logic [5:0] op6_b    = 6'h14;
    localparam logic [5:0] op6_bl   = 6'h15;
    localparam logic [5:0] op6_beq  = 6'h16;
    localparam logic [5:0] op6_bne  = 6'h17;

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {s_if, s_id, s_exe, s_mem, s_wb} cpu_state_t;

    typedef enum logic [2:0] {br_none, br_b, br_bl, br_beq, br_bne, br_jirl} br_kind_t;

endpackage

// File: design/decode_if.sv
`timescale 1ns/10ps

interface decode_if import cpu_pkg::*; ();
    alu_op_t  alu_op;
    logic     src1_is_pc;
    logic     src2_is_imm;
    word_t    imm;
    br_kind_t br_kind;
    word_t    br_offs;
    reg_idx_t rj;
    reg_idx_t rk_or_rd;
    reg_idx_t dest;
    logic     gr_we;
    logic     mem_we;
    logic     res_from_mem;

    modport dec (output alu_op, src1_is_pc, src2_is_imm, imm, br_kind, br_offs,
                 rj, rk_or_rd, dest, gr_we, mem_we, res_from_mem);
    modport core (input alu_op, src1_is_pc, src2_is_imm, imm, br_kind, br_offs,
                  rj, rk_or_rd, dest, gr_we, mem_we, res_from_mem);
endinterface

// File: design/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import cpu_pkg::*; (
    input word_t  inst,
    decode_if.dec ctrl
);
    reg_idx_t rd;
    reg_idx_t rk;
    word_t    si12;
    word_t    ui5;
    word_t    si20;
    word_t    offs16;
    word_t    offs26;
    alu_op_t  rr_op;
    logic     rr_hit;
    logic     is_shift;
    logic     rd_is_src;

    assign rd     = inst[4:0];
    assign rk     = inst[14:10];
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui5    = {27'b0, inst[14:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}; // offs[25:16] sits in inst[9:0].

    // register-register and shift-immediate forms share the 17-bit opcode field.
    always_comb begin
        rr_hit = 1'b1;
        case (inst[31:15])
            op17_add_w:  rr_op = alu_add;
            op17_sub_w:  rr_op = alu_sub;
            op17_slt:    rr_op = alu_slt;
            op17_sltu:   rr_op = alu_sltu;
            op17_nor:    rr_op = alu_nor;
            op17_and:    rr_op = alu_and;
            op17_or:     rr_op = alu_or;
            op17_xor:    rr_op = alu_xor;
            op17_slli_w: rr_op = alu_sll;
            op17_srli_w: rr_op = alu_srl;
            op17_srai_w: rr_op = alu_sra;
            default: begin
                rr_op  = alu_add;
                rr_hit = 1'b0;
            end
        endcase
    end

    assign is_shift  = rr_op inside {alu_sll, alu_srl, alu_sra};
    assign rd_is_src = (inst[31:22] == op10_st_w) || (inst[31:26] == op6_beq) ||
                       (inst[31:26] == op6_bne);

    assign ctrl.rj       = inst[9:5];
    assign ctrl.rk_or_rd = rd_is_src ? rd : rk;
    assign ctrl.dest     = (inst[31:26] == op6_bl) ? 5'd1 : rd;

    always_comb begin
        ctrl.alu_op       = alu_add;   // anything unmatched falls through as a no-op.
        ctrl.src1_is_pc   = 1'b0;
        ctrl.src2_is_imm  = 1'b0;
        ctrl.imm          = si12;
        ctrl.br_kind      = br_none;
        ctrl.br_offs      = offs16;
        ctrl.gr_we        = 1'b0;
        ctrl.mem_we       = 1'b0;
        ctrl.res_from_mem = 1'b0;
        if (rr_hit) begin
            ctrl.alu_op      = rr_op;
            ctrl.src2_is_imm = is_shift;
            ctrl.imm         = ui5;
            ctrl.gr_we       = 1'b1;
        end else if (inst[31:22] == op10_addi_w) begin
            ctrl.src2_is_imm = 1'b1;
            ctrl.gr_we       = 1'b1;
        end else if (inst[31:25] == op7_lu12i_w) begin
            ctrl.alu_op      = alu_lui;
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = si20;
            ctrl.gr_we       = 1'b1;
        end else if (inst[31:22] == op10_ld_w) begin
            ctrl.src2_is_imm  = 1'b1;
            ctrl.gr_we        = 1'b1;
            ctrl.res_from_mem = 1'b1;
        end else if (inst[31:22] == op10_st_w) begin
            ctrl.src2_is_imm = 1'b1;
            ctrl.mem_we      = 1'b1;
        end else if (inst[31:26] == op6_jirl || inst[31:26] == op6_bl) begin
            ctrl.src1_is_pc  = 1'b1;   // the link value is pc plus 4.
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = 32'd4;
            ctrl.gr_we       = 1'b1;
            ctrl.br_kind     = (inst[31:26] == op6_bl) ? br_bl : br_jirl;
            ctrl.br_offs     = (inst[31:26] == op6_bl) ? offs26 : offs16;
        end else if (inst[31:26] == op6_b) begin
            ctrl.br_kind = br_b;
            ctrl.br_offs = offs26;
        end else if (inst[31:26] == op6_beq) begin
            ctrl.br_kind = br_beq;
        end else if (inst[31:26] == op6_bne) begin
            ctrl.br_kind = br_bne;
        end
    end
endmodule

// File: design/mycpu_top.sv
`timescale 1ns/10ps

module mycpu_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output word_t    inst_sram_addr,
    input  word_t    inst_sram_rdata,
    output logic     data_sram_we,
    output word_t    data_sram_addr,
    output word_t    data_sram_wdata,
    input  word_t    data_sram_rdata,
    output word_t    debug_wb_pc,
    output logic     debug_wb_rf_we,
    output reg_idx_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);
    cpu_state_t state;
    word_t      pc;
    word_t      inst_q;
    word_t      rj_q;
    word_t      rkd_q;
    logic       taken_q;
    word_t      target_q;
    word_t      alu_q;
    word_t      load_q;

    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      alu_src1;
    word_t      alu_src2;
    word_t      alu_result;
    logic       br_taken;
    word_t      br_target;
    word_t      seq_pc;
    word_t      next_pc;
    word_t      wb_data;
    logic       rf_we;
    logic       branch_only;

    decode_if id_bus ();

    inst_decoder u_decoder (.inst(inst_q), .ctrl(id_bus.dec));

    regfile u_regfile (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (id_bus.dest),
        .raddr1 (id_bus.rj),
        .raddr2 (id_bus.rk_or_rd),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    alu u_alu (.op(id_bus.alu_op), .src1(alu_src1), .src2(alu_src2), .result(alu_result));

    branch_unit u_branch (
        .kind      (id_bus.br_kind),
        .pc        (pc),
        .rj_value  (rf_rdata1),
        .rkd_value (rf_rdata2),
        .offs      (id_bus.br_offs),
        .taken     (br_taken),
        .target    (br_target)
    );

    // ------------------------------------------------------------------------
    // state sequencing and pc
    // ------------------------------------------------------------------------
    assign branch_only = id_bus.br_kind inside {br_b, br_beq, br_bne};
    assign seq_pc      = pc + 32'd4;
    assign next_pc     = taken_q ? target_q : seq_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_if;
            pc    <= reset_pc;
        end else begin
            case (state)
                s_if: state <= s_id;
                s_id: begin
                    if (branch_only) begin
                        state <= s_if;
                        pc    <= br_taken ? br_target : seq_pc; // plain branches end here.
                    end else begin
                        state <= s_exe;
                    end
                end
                s_exe: state <= (id_bus.mem_we || id_bus.res_from_mem) ? s_mem : s_wb;
                s_mem: begin
                    if (id_bus.res_from_mem) begin
                        state <= s_wb;
                    end else begin
                        state <= s_if;   // stores have nothing to write back.
                        pc    <= next_pc;
                    end
                end
                s_wb: begin
                    state <= s_if;
                    pc    <= next_pc;
                end
                default: state <= s_if;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // stage registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            s_if: inst_q <= inst_sram_rdata;
            s_id: begin
                rj_q     <= rf_rdata1;
                rkd_q    <= rf_rdata2;
                taken_q  <= br_taken;
                target_q <= br_target;
            end
            s_exe: alu_q <= alu_result;
            s_mem: load_q <= data_sram_rdata;
            default: ;
        endcase
    end

    assign alu_src1 = id_bus.src1_is_pc ? pc : rj_q;
    assign alu_src2 = id_bus.src2_is_imm ? id_bus.imm : rkd_q;
    assign wb_data  = id_bus.res_from_mem ? load_q : alu_q;
    assign rf_we    = (state == s_wb) && id_bus.gr_we;

    // operands hold still after s_id, so the address stays valid into s_mem.
    assign inst_sram_addr  = pc;
    assign data_sram_we    = (state == s_exe) && id_bus.mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_q;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = id_bus.dest;
    assign debug_wb_rf_wdata = wb_data;

    // stores are whole words only.
    a_store_aligned: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (data_sram_addr[1:0] == 2'b00));
    // bl and jirl link to the instruction after them.
    a_link_value: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we && (id_bus.br_kind inside {br_bl, br_jirl}))
            |-> (debug_wb_rf_wdata == debug_wb_pc + 32'd4));
    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {s_if, s_id, s_exe, s_mem, s_wb});
endmodule

// File: design/regfile.sv
`timescale 1ns/10ps

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);
    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;   // r0 is never written.
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // one write per instruction, so writes never come back to back.
    a_single_write: assert property (@(posedge clk) we |=> !we);
endmodule

// File: mycpu_top.f
+incdir+verif
design/cpu_pkg.sv
design/decode_if.sv
design/inst_decoder.sv
design/alu.sv
design/regfile.sv
design/branch_unit.sv
design/mycpu_top.sv
verif/tb_mycpu_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the mycpu_top testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_mycpu_top -Mdir obj_dir -f mycpu_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_mycpu_top 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1

// File: verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: instruction word, cycles on the executed path (zero where skipped),
// traced flag, expected register number and expected write data.
typedef struct packed {
    word_t      inst;
    logic [3:0] cycles;
    logic       traced;
    reg_idx_t   wnum;
    word_t      wdata;
} prog_row_t;

typedef struct packed {
    word_t addr;
    word_t data;
} store_row_t;

localparam int prog_len  = 34;
localparam int store_len = 1;

// row i sits at reset_pc plus 4 times i.
prog_row_t program_rows [prog_len] = '{
    '{32'h02bf_ec02, 4'd4, 1'b1, 5'd2,  32'hffff_fffb},  // addi.w r2, r0, -5
    '{32'h0280_1c03, 4'd4, 1'b1, 5'd3,  32'h0000_0007},  // addi.w r3, r0, 7
    '{32'h0010_0c44, 4'd4, 1'b1, 5'd4,  32'h0000_0002},  // add.w r4, r2, r3
    '{32'h0011_0c45, 4'd4, 1'b1, 5'd5,  32'hffff_fff4},  // sub.w r5, r2, r3
    '{32'h0012_0c46, 4'd4, 1'b1, 5'd6,  32'h0000_0001},  // slt r6, r2, r3
    '{32'h0012_8c47, 4'd4, 1'b1, 5'd7,  32'h0000_0000},  // sltu r7, r2, r3
    '{32'h0014_1068, 4'd4, 1'b1, 5'd8,  32'hffff_fff8},  // nor r8, r3, r4
    '{32'h0014_8c49, 4'd4, 1'b1, 5'd9,  32'h0000_0003},  // and r9, r2, r3
    '{32'h0015_0c4a, 4'd4, 1'b1, 5'd10, 32'hffff_ffff},  // or r10, r2, r3
    '{32'h0015_8c4b, 4'd4, 1'b1, 5'd11, 32'hffff_fffc},  // xor r11, r2, r3
    '{32'h1424_68ac, 4'd4, 1'b1, 5'd12, 32'h1234_5000},  // lu12i.w r12, 0x12345
    '{32'h0040_904d, 4'd4, 1'b1, 5'd13, 32'hffff_ffb0},  // slli.w r13, r2, 4
    '{32'h0044_904e, 4'd4, 1'b1, 5'd14, 32'h0fff_ffff},  // srli.w r14, r2, 4
    '{32'h0048_904f, 4'd4, 1'b1, 5'd15, 32'hffff_ffff},  // srai.w r15, r2, 4
    '{32'h2980_400c, 4'd4, 1'b0, 5'd0,  32'h0000_0000},  // st.w r12, r0, 0x10
    '{32'h2880_4010, 4'd5, 1'b1, 5'd16, 32'h1234_5000},  // ld.w r16, r0, 0x10
    '{32'h2880_8011, 4'd5, 1'b1, 5'd17, 32'hc0de_0020},  // ld.w r17, r0, 0x20
    '{32'h5800_0c43, 4'd2, 1'b0, 5'd0,  32'h0000_0000},  // beq r2, r3, +12 not taken
    '{32'h0280_0414, 4'd4, 1'b1, 5'd20, 32'h0000_0001},  // addi.w r20, r0, 1
    '{32'h5c00_0843, 4'd2, 1'b0, 5'd0,  32'h0000_0000},  // bne r2, r3, +8 taken
    '{32'h0280_0415, 4'd0, 1'b0, 5'd0,  32'h0000_0000},  // addi.w r21, r0, 1 skipped
    '{32'h5800_0863, 4'd2, 1'b0, 5'd0,  32'h0000_0000},  // beq r3, r3, +8 taken
    '{32'h0280_0815, 4'd0, 1'b0, 5'd0,  32'h0000_0000},  // addi.w r21, r0, 2 skipped
    '{32'h5c00_0863, 4'd2, 1'b0, 5'd0,  32'h0000_0000},  // bne r3, r3, +8 not taken
    '{32'h0280_0c15, 4'd4, 1'b1, 5'd21, 32'h0000_0003},  // addi.w r21, r0, 3
    '{32'h5000_0800, 4'd2, 1'b0, 5'd0,  32'h0000_0000},  // b +8
    '{32'h0280_0416, 4'd0, 1'b0, 5'd0,  32'h0000_0000},  // addi.w r22, r0, 1 skipped
    '{32'h5400_0800, 4'd4, 1'b1, 5'd1,  32'h1c00_0070},  // bl +8
    '{32'h0280_0816, 4'd0, 1'b0, 5'd0,  32'h0000_0000},  // addi.w r22, r0, 2 skipped
    '{32'h4c00_0c38, 4'd4, 1'b1, 5'd24, 32'h1c00_0078},  // jirl r24, r1, 12
    '{32'h0280_0c16, 4'd0, 1'b0, 5'd0,  32'h0000_0000},  // addi.w r22, r0, 3 skipped
    '{32'h0010_0c40, 4'd4, 1'b1, 5'd0,  32'h0000_0002},  // add.w r0, r2, r3
    '{32'h0010_0c1a, 4'd4, 1'b1, 5'd26, 32'h0000_0007},  // add.w r26, r0, r3
    '{32'h5000_0000, 4'd2, 1'b0, 5'd0,  32'h0000_0000}   // b 0, the final self-loop
};

store_row_t store_rows [store_len] = '{
    '{32'h0000_0010, 32'h1234_5000}
};

`endif

// File: verif/tb_mycpu_top.sv
`timescale 1ns/10ps

module tb_mycpu_top import cpu_pkg::*; ();
    `include "tb_program.svh"

    logic     clk;
    logic     reset;
    word_t    inst_sram_addr;
    word_t    inst_sram_rdata = 32'd0;
    logic     data_sram_we;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata = 32'd0;
    word_t    debug_wb_pc;
    logic     debug_wb_rf_we;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t    data_mem [64];
    int       trace_pos = 0;   // program row of the next expected register write.
    int       store_pos = 0;
    word_t    end_pc;

    mycpu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int next_traced(input int from);
        int idx;
        idx = from;
        while (idx < prog_len && !program_rows[idx].traced) begin
            idx++;
        end
        return idx;
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = addr - reset_pc;
        if (offset < word_t'(prog_len * 4)) begin
            return program_rows[offset >> 2].inst;
        end
        return 32'd0;   // outside the program every word decodes as a no-op.
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t expected,
                                 input reg_idx_t actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_trace();
        if (trace_pos >= prog_len) begin
            $display("register r%0d was written after the last expected write", debug_wb_rf_wnum);
            stop_run();
        end else begin
            check_word("debug_wb_pc", reset_pc + word_t'(trace_pos * 4), debug_wb_pc);
            check_reg_idx("debug_wb_rf_wnum", program_rows[trace_pos].wnum, debug_wb_rf_wnum);
            check_word("debug_wb_rf_wdata", program_rows[trace_pos].wdata, debug_wb_rf_wdata);
            trace_pos = next_traced(trace_pos + 1);
        end
    endtask

    task automatic check_store();
        if (store_pos >= store_len) begin
            $display("the core stored to address %h, but no more stores were expected",
                     data_sram_addr);
            stop_run();
        end else begin
            check_word("data_sram_addr", store_rows[store_pos].addr, data_sram_addr);
            check_word("data_sram_wdata", store_rows[store_pos].data, data_sram_wdata);
            store_pos++;
        end
    endtask

    // ------------------------------------------------------------------------
    // memory models and trace monitor
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                data_mem[i] = 32'hc0de_0000 | word_t'(i * 4);  // each word carries its address.
            end
        end else begin
            if (debug_wb_rf_we) begin
                check_trace();
            end
            if (data_sram_we) begin
                check_store();
                data_mem[data_sram_addr[7:2]] = data_sram_wdata;
            end
        end
        inst_sram_rdata <= fetch_word(inst_sram_addr);
        data_sram_rdata <= data_mem[data_sram_addr[7:2]];
    end

    initial begin
        reset     = 1'b1;
        end_pc    = reset_pc + word_t'((prog_len - 1) * 4);
        trace_pos = next_traced(0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        while (inst_sram_addr !== end_pc) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // one more pass through the self-loop.
        if (trace_pos != prog_len || store_pos != store_len) begin
            $display("the program ended before every expected write and store was seen");
            stop_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // watchdog sized from the cycle counts in the program table.
    initial begin
        int total_cycles;
        total_cycles = 0;
        for (int i = 0; i < prog_len; i++) begin
            total_cycles += int'(program_rows[i].cycles);
        end
        #((total_cycles + 20) * 20);
        $display("timeout: the program did not reach its final loop within %0d cycles",
                 total_cycles + 20);
        stop_run();
    end
endmodule
